// ==== Makefile ====
SIM = obj_dir/Vnw_aligner_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f nw_aligner.f --top-module nw_aligner_tb -Mdir obj_dir

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== logic/nw_align_emit.sv ====
`timescale 1ns/1ps

module nw_align_emit (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    nw_trace_if.emitter     trace,
    output logic            out_valid,
    output nw_pkg::symbol_t out_a,
    output nw_pkg::symbol_t out_b,
    output nw_pkg::score_t  final_score,
    output logic            done
);

    nw_pkg::score_t delta;

    always_comb begin
        case (trace.arrow)
            nw_pkg::ARROW_DIAG: delta = (trace.sym_a == trace.sym_b) ? nw_pkg::MATCH_SCORE
                                                                     : nw_pkg::MISMATCH_SCORE;
            nw_pkg::ARROW_UP,
            nw_pkg::ARROW_LEFT: delta = nw_pkg::GAP_SCORE;
            default:            delta = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid   <= 1'b0;
            done        <= 1'b0;
            final_score <= '0;
        end else begin
            out_valid <= trace.step;
            done      <= trace.step && trace.last;
            if (start) begin
                final_score <= '0;         // New run
            end else if (trace.step) begin
                final_score <= final_score + delta;
            end
        end
    end

    // Aligned pair, dash on the gapped side
    always_ff @(posedge clk) begin
        if (trace.step) begin
            case (trace.arrow)
                nw_pkg::ARROW_DIAG: begin
                    out_a <= trace.sym_a;
                    out_b <= trace.sym_b;
                end
                nw_pkg::ARROW_UP: begin
                    out_a <= trace.sym_a;
                    out_b <= nw_pkg::DASH;
                end
                nw_pkg::ARROW_LEFT: begin
                    out_a <= nw_pkg::DASH;
                    out_b <= trace.sym_b;
                end
                default: begin
                    out_a <= nw_pkg::DASH;
                    out_b <= nw_pkg::DASH;
                end
            endcase
        end
    end

endmodule

// ==== logic/nw_aligner.sv ====
`timescale 1ns/1ps

module nw_aligner (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_a,
    input  logic            load_b,
    input  nw_pkg::index_t  load_idx,
    input  nw_pkg::symbol_t load_sym,
    input  nw_pkg::index_t  len_a,
    input  nw_pkg::index_t  len_b,
    input  logic            start,
    output logic            busy,
    output logic            out_valid,
    output nw_pkg::symbol_t out_a,
    output nw_pkg::symbol_t out_b,
    output nw_pkg::score_t  final_score,
    output logic            done
);

    nw_pkg::index_t  fill_i;
    nw_pkg::index_t  fill_j;
    nw_pkg::symbol_t fill_a;
    nw_pkg::symbol_t fill_b;
    nw_pkg::index_t  trace_i;
    nw_pkg::index_t  trace_j;
    nw_pkg::symbol_t trace_a;
    nw_pkg::symbol_t trace_b;
    logic            wr_en;
    nw_pkg::addr_t   wr_addr;
    nw_pkg::arrow_t  wr_arrow;
    logic            rd_en;
    nw_pkg::addr_t   rd_addr;
    nw_pkg::arrow_t  rd_arrow;
    logic            fill_done;
    logic            filling;
    logic            tracing;
    logic            run_start;

    nw_trace_if trace_bus ();

    assign busy      = filling | tracing;
    assign run_start = start & ~busy;      // Drop start during a run

    nw_seq_buffer u_seq_buffer (
        .clk(clk), .rst(rst), .load_a(load_a), .load_b(load_b),
        .load_idx(load_idx), .load_sym(load_sym),
        .fill_i(fill_i), .fill_j(fill_j), .trace_i(trace_i), .trace_j(trace_j),
        .fill_a(fill_a), .fill_b(fill_b), .trace_a(trace_a), .trace_b(trace_b)
    );

    nw_fill_engine u_fill_engine (
        .clk(clk), .rst(rst), .start(run_start), .len_a(len_a), .len_b(len_b),
        .sym_a(fill_a), .sym_b(fill_b), .fill_i(fill_i), .fill_j(fill_j),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_arrow(wr_arrow),
        .fill_done(fill_done), .filling(filling)
    );

    nw_arrow_mem u_arrow_mem (
        .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_arrow(wr_arrow),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_arrow(rd_arrow)
    );

    nw_traceback u_traceback (
        .clk(clk), .rst(rst), .fill_done(fill_done), .len_a(len_a), .len_b(len_b),
        .rd_arrow(rd_arrow), .sym_a(trace_a), .sym_b(trace_b),
        .trace_i(trace_i), .trace_j(trace_j), .rd_en(rd_en), .rd_addr(rd_addr),
        .tracing(tracing), .trace(trace_bus.tracer)
    );

    nw_align_emit u_align_emit (
        .clk(clk), .rst(rst), .start(run_start), .trace(trace_bus.emitter),
        .out_valid(out_valid), .out_a(out_a), .out_b(out_b),
        .final_score(final_score), .done(done)
    );

endmodule

// ==== logic/nw_arrow_mem.sv ====
`timescale 1ns/1ps

module nw_arrow_mem (
    input  logic           clk,
    input  logic           wr_en,
    input  nw_pkg::addr_t  wr_addr,
    input  nw_pkg::arrow_t wr_arrow,
    input  logic           rd_en,
    input  nw_pkg::addr_t  rd_addr,
    output nw_pkg::arrow_t rd_arrow
);

    localparam int DEPTH = nw_pkg::SEQ_LEN * nw_pkg::SEQ_LEN;

    nw_pkg::arrow_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_arrow;
        end
    end

    // Read data valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_arrow <= mem[rd_addr];
        end
    end

endmodule

// ==== logic/nw_fill_engine.sv ====
`timescale 1ns/1ps

module nw_fill_engine (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  nw_pkg::index_t  len_a,
    input  nw_pkg::index_t  len_b,
    input  nw_pkg::symbol_t sym_a,
    input  nw_pkg::symbol_t sym_b,
    output nw_pkg::index_t  fill_i,
    output nw_pkg::index_t  fill_j,
    output logic            wr_en,
    output nw_pkg::addr_t   wr_addr,
    output nw_pkg::arrow_t  wr_arrow,
    output logic            fill_done,
    output logic            filling
);

    nw_pkg::score_t row_buf [nw_pkg::SEQ_LEN];    // Row i-1, column j at slot j-1
    nw_pkg::score_t left_score;
    nw_pkg::score_t diag_score;
    nw_pkg::score_t diag_cand;
    nw_pkg::score_t up_cand;
    nw_pkg::score_t left_cand;
    nw_pkg::score_t best;
    nw_pkg::index_t i_m1;
    nw_pkg::index_t j_m1;
    logic           active;
    logic           last_cell;
    logic           row_end;

    // Score of row 0 / column 0 at index k
    function automatic nw_pkg::score_t edge_score(input nw_pkg::index_t k);
        return nw_pkg::GAP_SCORE * $signed({3'b000, k});
    endfunction

    assign i_m1      = fill_i - nw_pkg::index_t'(1);
    assign j_m1      = fill_j - nw_pkg::index_t'(1);
    assign row_end   = (fill_j == len_b);
    assign last_cell = row_end && (fill_i == len_a);

    assign diag_cand = diag_score + ((sym_a == sym_b) ? nw_pkg::MATCH_SCORE
                                                      : nw_pkg::MISMATCH_SCORE);
    assign up_cand   = row_buf[j_m1[nw_pkg::POS_W-1:0]] + nw_pkg::GAP_SCORE;
    assign left_cand = left_score + nw_pkg::GAP_SCORE;

    // Ties resolve diagonal, then up, then left
    always_comb begin
        if (diag_cand >= up_cand && diag_cand >= left_cand) begin
            best     = diag_cand;
            wr_arrow = nw_pkg::ARROW_DIAG;
        end else if (up_cand >= left_cand) begin
            best     = up_cand;
            wr_arrow = nw_pkg::ARROW_UP;
        end else begin
            best     = left_cand;
            wr_arrow = nw_pkg::ARROW_LEFT;
        end
    end

    assign wr_en   = active;
    assign wr_addr = {i_m1[nw_pkg::POS_W-1:0], j_m1[nw_pkg::POS_W-1:0]};
    assign filling = active | fill_done;          // No busy gap before traceback starts

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            fill_done <= 1'b0;
            fill_i    <= '0;
            fill_j    <= '0;
        end else begin
            fill_done <= 1'b0;
            if (start && !filling) begin
                active <= 1'b1;
                fill_i <= nw_pkg::index_t'(1);
                fill_j <= nw_pkg::index_t'(1);
            end else if (active) begin
                if (last_cell) begin
                    active    <= 1'b0;
                    fill_done <= 1'b1;
                end else if (row_end) begin
                    fill_i <= fill_i + nw_pkg::index_t'(1);
                    fill_j <= nw_pkg::index_t'(1);
                end else begin
                    fill_j <= fill_j + nw_pkg::index_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !filling) begin
            for (int k = 0; k < nw_pkg::SEQ_LEN; k++) begin
                row_buf[k] <= edge_score(nw_pkg::index_t'(k + 1));
            end
            diag_score <= '0;
            left_score <= edge_score(nw_pkg::index_t'(1));
        end else if (active) begin
            row_buf[j_m1[nw_pkg::POS_W-1:0]] <= best;
            if (row_end) begin
                diag_score <= edge_score(fill_i);  // Column 0 of the new row's upper neighbor
                left_score <= edge_score(fill_i + nw_pkg::index_t'(1));
            end else begin
                diag_score <= row_buf[j_m1[nw_pkg::POS_W-1:0]];
                left_score <= best;
            end
        end
    end

endmodule

// ==== logic/nw_pkg.sv ====
package nw_pkg;

    localparam int SEQ_LEN = 16;
    localparam int POS_W   = $clog2(SEQ_LEN);        // Bits for a position inside one sequence
    localparam int INDEX_W = $clog2(SEQ_LEN + 1);    // Matrix index 0..SEQ_LEN
    localparam int ADDR_W  = 2 * POS_W;
    localparam int SCORE_W = 8;                      // Covers -4*SEQ_LEN up to SEQ_LEN

    typedef logic [2:0]               symbol_t;
    typedef logic [2:0]               arrow_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic signed [SCORE_W-1:0] score_t;

    // Nucleotide codes
    localparam symbol_t SYM_A = 3'b000;
    localparam symbol_t SYM_C = 3'b001;
    localparam symbol_t SYM_G = 3'b010;
    localparam symbol_t SYM_T = 3'b011;
    localparam symbol_t DASH  = 3'b111;              // Gap in the aligned output

    // One-hot traceback directions
    localparam arrow_t ARROW_DIAG = 3'b001;
    localparam arrow_t ARROW_UP   = 3'b010;
    localparam arrow_t ARROW_LEFT = 3'b100;

    // Linear gap scoring
    localparam score_t MATCH_SCORE    = 8'sd1;
    localparam score_t MISMATCH_SCORE = -8'sd1;
    localparam score_t GAP_SCORE      = -8'sd2;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        STEP,
        FINISH
    } trace_state_t;

endpackage

// ==== logic/nw_seq_buffer.sv ====
`timescale 1ns/1ps

module nw_seq_buffer (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_a,
    input  logic            load_b,
    input  nw_pkg::index_t  load_idx,
    input  nw_pkg::symbol_t load_sym,
    input  nw_pkg::index_t  fill_i,
    input  nw_pkg::index_t  fill_j,
    input  nw_pkg::index_t  trace_i,
    input  nw_pkg::index_t  trace_j,
    output nw_pkg::symbol_t fill_a,
    output nw_pkg::symbol_t fill_b,
    output nw_pkg::symbol_t trace_a,
    output nw_pkg::symbol_t trace_b
);

    nw_pkg::symbol_t seq_a [nw_pkg::SEQ_LEN];
    nw_pkg::symbol_t seq_b [nw_pkg::SEQ_LEN];

    nw_pkg::index_t fill_i_m1;
    nw_pkg::index_t fill_j_m1;
    nw_pkg::index_t trace_i_m1;
    nw_pkg::index_t trace_j_m1;

    // Matrix index k maps to stored position k-1
    assign fill_i_m1  = fill_i - nw_pkg::index_t'(1);
    assign fill_j_m1  = fill_j - nw_pkg::index_t'(1);
    assign trace_i_m1 = trace_i - nw_pkg::index_t'(1);
    assign trace_j_m1 = trace_j - nw_pkg::index_t'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < nw_pkg::SEQ_LEN; k++) begin
                seq_a[k] <= nw_pkg::SYM_A;
                seq_b[k] <= nw_pkg::SYM_A;
            end
        end else begin
            if (load_a) seq_a[load_idx[nw_pkg::POS_W-1:0]] <= load_sym;
            if (load_b) seq_b[load_idx[nw_pkg::POS_W-1:0]] <= load_sym;
        end
    end

    assign fill_a  = seq_a[fill_i_m1[nw_pkg::POS_W-1:0]];
    assign fill_b  = seq_b[fill_j_m1[nw_pkg::POS_W-1:0]];
    assign trace_a = seq_a[trace_i_m1[nw_pkg::POS_W-1:0]];   // Unused on row 0
    assign trace_b = seq_b[trace_j_m1[nw_pkg::POS_W-1:0]];   // Unused on column 0

endmodule

// ==== logic/nw_trace_if.sv ====
`timescale 1ns/1ps

interface nw_trace_if;

    logic            step;       // Qualifies the other four
    nw_pkg::arrow_t  arrow;
    nw_pkg::symbol_t sym_a;
    nw_pkg::symbol_t sym_b;
    logic            last;       // Step into the origin

    modport tracer (
        output step, arrow, sym_a, sym_b, last
    );

    modport emitter (
        input step, arrow, sym_a, sym_b, last
    );

endinterface

// ==== logic/nw_traceback.sv ====
`timescale 1ns/1ps

module nw_traceback (
    input  logic            clk,
    input  logic            rst,
    input  logic            fill_done,
    input  nw_pkg::index_t  len_a,
    input  nw_pkg::index_t  len_b,
    input  nw_pkg::arrow_t  rd_arrow,
    input  nw_pkg::symbol_t sym_a,
    input  nw_pkg::symbol_t sym_b,
    output nw_pkg::index_t  trace_i,
    output nw_pkg::index_t  trace_j,
    output logic            rd_en,
    output nw_pkg::addr_t   rd_addr,
    output logic            tracing,
    nw_trace_if.tracer      trace
);

    nw_pkg::trace_state_t state;
    nw_pkg::index_t       pos_i;
    nw_pkg::index_t       pos_j;
    nw_pkg::index_t       pos_i_m1;
    nw_pkg::index_t       pos_j_m1;
    nw_pkg::index_t       next_i;
    nw_pkg::index_t       next_j;
    nw_pkg::arrow_t       move;
    logic                 on_edge;
    logic                 at_origin;

    assign pos_i_m1 = pos_i - nw_pkg::index_t'(1);
    assign pos_j_m1 = pos_j - nw_pkg::index_t'(1);
    assign on_edge  = (pos_i == '0) || (pos_j == '0);

    assign rd_en   = (state == nw_pkg::READ) && !on_edge;   // Boundary cells need no lookup
    assign rd_addr = {pos_i_m1[nw_pkg::POS_W-1:0], pos_j_m1[nw_pkg::POS_W-1:0]};

    always_comb begin
        if (pos_i == '0)      move = nw_pkg::ARROW_LEFT;
        else if (pos_j == '0) move = nw_pkg::ARROW_UP;
        else                  move = rd_arrow;
    end

    always_comb begin
        next_i = pos_i;
        next_j = pos_j;
        case (move)
            nw_pkg::ARROW_DIAG: begin
                next_i = pos_i_m1;
                next_j = pos_j_m1;
            end
            nw_pkg::ARROW_UP:   next_i = pos_i_m1;
            nw_pkg::ARROW_LEFT: next_j = pos_j_m1;
            default: ;
        endcase
    end

    assign at_origin = (next_i == '0) && (next_j == '0);

    assign trace.step  = (state == nw_pkg::STEP);
    assign trace.arrow = move;
    assign trace.sym_a = sym_a;
    assign trace.sym_b = sym_b;
    assign trace.last  = (state == nw_pkg::STEP) && at_origin;

    assign trace_i = pos_i;
    assign trace_j = pos_j;
    assign tracing = (state != nw_pkg::IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= nw_pkg::IDLE;
            pos_i <= '0;
            pos_j <= '0;
        end else begin
            case (state)
                nw_pkg::IDLE: begin
                    if (fill_done) begin
                        pos_i <= len_a;            // Start at bottom-right corner
                        pos_j <= len_b;
                        state <= nw_pkg::READ;
                    end
                end
                nw_pkg::READ: state <= nw_pkg::STEP;
                nw_pkg::STEP: begin
                    pos_i <= next_i;
                    pos_j <= next_j;
                    state <= at_origin ? nw_pkg::FINISH : nw_pkg::READ;
                end
                default: state <= nw_pkg::IDLE;
            endcase
        end
    end

endmodule

// ==== nw_aligner.f ====
+incdir+tests
logic/nw_pkg.sv
logic/nw_trace_if.sv
logic/nw_seq_buffer.sv
logic/nw_fill_engine.sv
logic/nw_arrow_mem.sv
logic/nw_traceback.sv
logic/nw_align_emit.sv
logic/nw_aligner.sv
tests/nw_aligner_tb.sv

// ==== tests/nw_model.svh ====
`ifndef NW_MODEL_SVH
`define NW_MODEL_SVH

int              model_h   [0:nw_pkg::SEQ_LEN][0:nw_pkg::SEQ_LEN];
int              model_dir [0:nw_pkg::SEQ_LEN][0:nw_pkg::SEQ_LEN];   // 0 diag, 1 up, 2 left
nw_pkg::symbol_t exp_a [$];
nw_pkg::symbol_t exp_b [$];
int              exp_score;

// Pairs come out from the corner back to the origin
function automatic void build_expected(input int la, input int lb);
    int gap;
    int diag;
    int up;
    int left;
    int i;
    int j;
    int move;
    gap = int'(nw_pkg::GAP_SCORE);
    for (i = 0; i <= la; i++) model_h[i][0] = gap * i;
    for (j = 0; j <= lb; j++) model_h[0][j] = gap * j;
    for (i = 1; i <= la; i++) begin
        for (j = 1; j <= lb; j++) begin
            diag = model_h[i-1][j-1] + ((seq_a[i-1] == seq_b[j-1]) ?
                   int'(nw_pkg::MATCH_SCORE) : int'(nw_pkg::MISMATCH_SCORE));
            up   = model_h[i-1][j] + gap;
            left = model_h[i][j-1] + gap;
            if (diag >= up && diag >= left) begin
                model_h[i][j]   = diag;
                model_dir[i][j] = 0;
            end else if (up >= left) begin
                model_h[i][j]   = up;
                model_dir[i][j] = 1;
            end else begin
                model_h[i][j]   = left;
                model_dir[i][j] = 2;
            end
        end
    end
    exp_score = model_h[la][lb];
    exp_a.delete();
    exp_b.delete();
    i = la;
    j = lb;
    while (i > 0 || j > 0) begin
        if (i == 0)      move = 2;     // Top row only goes left
        else if (j == 0) move = 1;
        else             move = model_dir[i][j];
        case (move)
            0: begin
                exp_a.push_back(seq_a[i-1]);
                exp_b.push_back(seq_b[j-1]);
                i--;
                j--;
            end
            1: begin
                exp_a.push_back(seq_a[i-1]);
                exp_b.push_back(nw_pkg::DASH);
                i--;
            end
            default: begin
                exp_a.push_back(nw_pkg::DASH);
                exp_b.push_back(seq_b[j-1]);
                j--;
            end
        endcase
    end
endfunction

`endif

// ==== tests/nw_aligner_tb.sv ====
`timescale 1ns/1ps

module nw_aligner_tb;

    logic            clk = 1'b0;
    logic            rst;
    logic            load_a;
    logic            load_b;
    nw_pkg::index_t  load_idx;
    nw_pkg::symbol_t load_sym;
    nw_pkg::index_t  len_a;
    nw_pkg::index_t  len_b;
    logic            start;
    logic            busy;
    logic            out_valid;
    nw_pkg::symbol_t out_a;
    nw_pkg::symbol_t out_b;
    nw_pkg::score_t  final_score;
    logic            done;

    nw_pkg::symbol_t seq_a [nw_pkg::SEQ_LEN];
    nw_pkg::symbol_t seq_b [nw_pkg::SEQ_LEN];
    nw_pkg::symbol_t got_a [$];
    nw_pkg::symbol_t got_b [$];
    int              got_score;
    int              got_cycles;
    int              seed;
    int              cycle_count = 0;

    `include "nw_model.svh"

    nw_aligner dut (
        .clk(clk), .rst(rst), .load_a(load_a), .load_b(load_b),
        .load_idx(load_idx), .load_sym(load_sym), .len_a(len_a), .len_b(len_b),
        .start(start), .busy(busy), .out_valid(out_valid), .out_a(out_a),
        .out_b(out_b), .final_score(final_score), .done(done)
    );

    always #4 clk = ~clk;

    // About 25 runs of at most 600 cycles each
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == 20000) begin
            $display("Timeout: the tests did not finish within 20000 cycles");
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, got);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_condition(input bit ok, input string what);
        assert (ok) else begin
            $display("Error at %0t: %s", $time, what);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic nw_pkg::symbol_t to_symbol(input byte c);
        case (c)
            "C":     return nw_pkg::SYM_C;
            "G":     return nw_pkg::SYM_G;
            "T":     return nw_pkg::SYM_T;
            default: return nw_pkg::SYM_A;
        endcase
    endfunction

    task automatic set_from_text(input string a, input string b);
        for (int k = 0; k < a.len(); k++) seq_a[k] = to_symbol(a[k]);
        for (int k = 0; k < b.len(); k++) seq_b[k] = to_symbol(b[k]);
    endtask

    task automatic set_random(input int la, input int lb);
        for (int k = 0; k < la; k++) seq_a[k] = nw_pkg::symbol_t'($unsigned($random(seed)) % 4);
        for (int k = 0; k < lb; k++) seq_b[k] = nw_pkg::symbol_t'($unsigned($random(seed)) % 4);
    endtask

    task automatic load_sequences(input int la, input int lb);
        @(negedge clk);
        while (busy) @(negedge clk);
        for (int k = 0; k < la; k++) begin
            @(posedge clk);
            len_a    <= nw_pkg::index_t'(la);
            len_b    <= nw_pkg::index_t'(lb);
            load_a   <= 1'b1;
            load_idx <= nw_pkg::index_t'(k);
            load_sym <= seq_a[k];
        end
        for (int k = 0; k < lb; k++) begin
            @(posedge clk);
            load_a   <= 1'b0;
            load_b   <= 1'b1;
            load_idx <= nw_pkg::index_t'(k);
            load_sym <= seq_b[k];
        end
        @(posedge clk);
        load_b <= 1'b0;
    endtask

    // poke_start drives extra starts during the fill and during the traceback
    task automatic run_alignment(input int la, input int lb, input bit poke_start);
        int n;
        bit finished;
        load_sequences(la, lb);
        got_a.delete();
        got_b.delete();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("busy", int'(busy), 1);
        check_value("final_score", int'(final_score), 0);
        n = 0;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk);
            start <= poke_start && (n == 6 || n == la * lb + 4);
            @(negedge clk);
            n++;
            if (out_valid) begin
                got_a.push_back(out_a);
                got_b.push_back(out_b);
            end
            if (done) finished = 1'b1;
        end
        got_score  = int'(final_score);
        got_cycles = n;
    endtask

    task automatic compare_with_model(input int la, input int lb);
        build_expected(la, lb);
        check_value("pair count", got_a.size(), exp_a.size());
        for (int k = 0; k < exp_a.size(); k++) begin
            check_value($sformatf("out_a[%0d]", k), int'(got_a[k]), int'(exp_a[k]));
            check_value($sformatf("out_b[%0d]", k), int'(got_b[k]), int'(exp_b[k]));
        end
        check_value("final_score", got_score, exp_score);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("busy", int'(busy), 0);
        check_value("out_valid", int'(out_valid), 0);
        check_value("done", int'(done), 0);
        check_value("final_score", int'(final_score), 0);
    endtask

    task automatic test_identical();
        set_from_text("ACGTTGCA", "ACGTTGCA");
        run_alignment(8, 8, 1'b0);
        check_value("pair count", got_a.size(), 8);
        check_value("final_score", got_score, 8);   // Eight matches
        for (int k = 0; k < got_a.size(); k++) begin
            check_condition(got_a[k] != nw_pkg::DASH, "identical sequences produced a gap");
            check_value($sformatf("out_b[%0d]", k), int'(got_b[k]), int'(got_a[k]));
        end
        compare_with_model(8, 8);
    endtask

    task automatic test_unequal_lengths();
        set_from_text("GATTA", "GCATGCTAG");
        run_alignment(5, 9, 1'b0);
        check_condition(got_a.size() >= 9, "fewer pairs than the longer sequence");
        compare_with_model(5, 9);
    endtask

    task automatic test_random();
        int la;
        int lb;
        for (int r = 0; r < 20; r++) begin
            la = 1 + int'($unsigned($random(seed)) % nw_pkg::SEQ_LEN);
            lb = 1 + int'($unsigned($random(seed)) % nw_pkg::SEQ_LEN);
            set_random(la, lb);
            run_alignment(la, lb, 1'b0);
            compare_with_model(la, lb);
        end
    endtask

    task automatic test_start_while_busy();
        nw_pkg::symbol_t keep_a [$];
        nw_pkg::symbol_t keep_b [$];
        int              keep_score;
        int              keep_cycles;
        set_from_text("TGCATCA", "TCGACT");
        run_alignment(7, 6, 1'b1);
        compare_with_model(7, 6);
        keep_a      = got_a;
        keep_b      = got_b;
        keep_score  = got_score;
        keep_cycles = got_cycles;
        run_alignment(7, 6, 1'b0);               // Same input, undisturbed
        check_value("pair count", got_a.size(), keep_a.size());
        for (int k = 0; k < keep_a.size(); k++) begin
            check_value($sformatf("out_a[%0d]", k), int'(got_a[k]), int'(keep_a[k]));
            check_value($sformatf("out_b[%0d]", k), int'(got_b[k]), int'(keep_b[k]));
        end
        check_value("final_score", got_score, keep_score);
        check_value("cycles to done", got_cycles, keep_cycles);
        set_from_text("CCCC", "GGGGGG");
        run_alignment(4, 6, 1'b0);
        compare_with_model(4, 6);
    endtask

    initial begin
        seed = 53377;
        rst      <= 1'b1;
        load_a   <= 1'b0;
        load_b   <= 1'b0;
        load_idx <= '0;
        load_sym <= '0;
        len_a    <= nw_pkg::index_t'(1);
        len_b    <= nw_pkg::index_t'(1);
        start    <= 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_identical();
        test_unequal_lengths();
        test_random();
        test_start_while_busy();
        $display("Test completed successfully");
        $finish;
    end

endmodule
